/* command/command_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module command_sequencer (
    input  wire                    clk,
    input  wire                    rst,
    input  wire logic              rx_packet_done,
    input  wire logic              rx_packet_error,
    input  wire s3g_pkg::byte_t    rx_payload_len,
    input  wire s3g_pkg::payload_t rx_payload,
    input  wire logic              tx_busy,
    input  wire logic              ints_req,
    output s3g_pkg::reply_e        reply_kind,
    output s3g_pkg::byte_t         in_sel,
    output logic                   reg_wr,
    output s3g_pkg::byte_t         reg_addr,
    output s3g_pkg::word_t         reg_data,
    output s3g_pkg::word_t         out_stbs,
    output logic                   clear_wr,
    output s3g_pkg::word_t         clear_bits,
    output logic                   mask_wr,
    output s3g_pkg::word_t         mask_bits,
    output logic                   ints_ack
);
    import s3g_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_DELAY,
        ST_BUSY,
        ST_READ_SEL,
        ST_READ_SAMPLE,
        ST_READ_ISSUE
    } state_e;

    state_e  state;
    state_e  state_next;
    opcode_e opcode;
    word_t   arg_word;
    word_t   stbs_next;
    logic    reg_wr_next;
    logic    clear_wr_next;
    logic    mask_wr_next;
    logic    ints_ack_next;
    logic    sel_load;

    assign opcode = opcode_e'(rx_payload[0]);
    assign arg_word = rx_payload[4:1];  // Little-endian argument

    always_comb
    begin
        state_next = state;
        reply_kind = REPLY_NONE;
        stbs_next = '0;
        reg_wr_next = 1'b0;
        clear_wr_next = 1'b0;
        mask_wr_next = 1'b0;
        ints_ack_next = 1'b0;
        sel_load = 1'b0;

        case (state)
            ST_IDLE:
            begin
                if (rx_packet_done)
                begin
                    state_next = ST_DELAY;
                    if (rx_payload_len == 8'd0)
                        reply_kind = REPLY_OK;
                    else
                    begin
                        case (opcode)
                            OP_VERSION:
                                reply_kind = REPLY_VERSION;
                            OP_WRITE_OUT_REG:
                            begin
                                reg_wr_next = 1'b1;
                                reply_kind = REPLY_OK;
                            end
                            OP_READ_IN_REG:
                            begin
                                sel_load = 1'b1;
                                state_next = ST_READ_SEL;  // Reply comes later
                            end
                            OP_OUT_STBS:
                            begin
                                stbs_next = arg_word;
                                reply_kind = REPLY_OK;
                            end
                            OP_CLEAR_INTS:
                            begin
                                clear_wr_next = 1'b1;
                                reply_kind = REPLY_OK;
                            end
                            OP_MASK_INTS:
                            begin
                                mask_wr_next = 1'b1;
                                reply_kind = REPLY_OK;
                            end
                            default:
                                reply_kind = REPLY_UNKNOWN;
                        endcase
                    end
                end
                else if (rx_packet_error)
                begin
                    reply_kind = REPLY_ERROR;
                    state_next = ST_DELAY;
                end
                else if (ints_req)
                begin
                    // Unsolicited report, timer reload follows
                    reply_kind = REPLY_INTERRUPT;
                    ints_ack_next = 1'b1;
                    state_next = ST_DELAY;
                end
            end
            ST_DELAY:
                state_next = ST_BUSY;  // Let tx_busy rise first
            ST_BUSY:
            begin
                if (!tx_busy)
                    state_next = ST_IDLE;
            end
            ST_READ_SEL:
                state_next = ST_READ_SAMPLE;
            ST_READ_SAMPLE:
                state_next = ST_READ_ISSUE;
            ST_READ_ISSUE:
            begin
                reply_kind = REPLY_READ_REG;
                state_next = ST_DELAY;
            end
            default:
                state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= ST_IDLE;
            out_stbs <= '0;
            reg_wr <= 1'b0;
            clear_wr <= 1'b0;
            mask_wr <= 1'b0;
            ints_ack <= 1'b0;
            in_sel <= '0;
        end
        else
        begin
            state <= state_next;
            out_stbs <= stbs_next;
            reg_wr <= reg_wr_next;
            clear_wr <= clear_wr_next;
            mask_wr <= mask_wr_next;
            ints_ack <= ints_ack_next;
            if (sel_load)
                in_sel <= rx_payload[1];
        end
    end

    // Arguments, qualified by the strobes above
    always_ff @(posedge clk)
    begin
        reg_addr <= rx_payload[1];
        reg_data <= rx_payload[5:2];
        clear_bits <= arg_word;
        mask_bits <= arg_word;
    end

endmodule

`default_nettype wire

/* command/reply_formatter.sv */
`timescale 1ns/1ps
`default_nettype none

module reply_formatter #(
    parameter int NUM_IN_REGS = 8
) (
    input  wire                  clk,
    input  wire                  rst,
    input  wire s3g_pkg::reply_e reply_kind,
    input  wire s3g_pkg::byte_t  in_sel,
    input  wire s3g_pkg::word_t  in_regs [NUM_IN_REGS],
    input  wire s3g_pkg::word_t  ints_pending,
    output logic                 tx_packet_wr,
    output s3g_pkg::byte_t       tx_payload_len,
    output s3g_pkg::payload_t    tx_payload
);
    import s3g_pkg::*;

    localparam int SEL_W = (NUM_IN_REGS > 1) ? $clog2(NUM_IN_REGS) : 1;

    word_t in_word;

    // Input word sampled every cycle
    always_ff @(posedge clk)
    begin
        if (int'(in_sel) < NUM_IN_REGS)
            in_word <= in_regs[in_sel[SEL_W-1:0]];
        else
            in_word <= '0;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            tx_packet_wr <= 1'b0;
            tx_payload_len <= '0;
            tx_payload <= '0;
        end
        else
        begin
            tx_packet_wr <= (reply_kind != REPLY_NONE);
            tx_payload_len <= '0;
            tx_payload <= '0;  // Unused bytes stay zero
            case (reply_kind)
                REPLY_OK:
                begin
                    tx_payload_len <= 8'd1;
                    tx_payload[0] <= RC_OK;
                end
                REPLY_ERROR:
                begin
                    tx_payload_len <= 8'd1;
                    tx_payload[0] <= RC_ERROR;
                end
                REPLY_UNKNOWN:
                begin
                    tx_payload_len <= 8'd1;
                    tx_payload[0] <= RC_UNKNOWN;
                end
                REPLY_VERSION:
                begin
                    tx_payload_len <= 8'd3;
                    tx_payload[0] <= RC_OK;
                    tx_payload[1] <= VERSION_LO;
                    tx_payload[2] <= VERSION_HI;
                end
                REPLY_READ_REG:
                begin
                    tx_payload_len <= 8'd5;
                    tx_payload[0] <= RC_OK;
                    tx_payload[4:1] <= in_word;  // LSB first
                end
                REPLY_INTERRUPT:
                begin
                    tx_payload_len <= 8'd5;
                    tx_payload[0] <= RC_INTERRUPT;
                    tx_payload[4:1] <= ints_pending;
                end
                default:
                begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* common/s3g_pkg.sv */
`default_nettype none

package s3g_pkg;

    localparam int PAYLOAD_BYTES = 16;

    typedef logic [7:0] byte_t;
    typedef logic [31:0] word_t;
    typedef byte_t [PAYLOAD_BYTES-1:0] payload_t;  // Byte 0 is opcode or reply code

    // Request opcodes in payload byte 0
    typedef enum logic [7:0] {
        OP_VERSION       = 8'd0,
        OP_WRITE_OUT_REG = 8'd60,
        OP_READ_IN_REG   = 8'd61,
        OP_OUT_STBS      = 8'd62,
        OP_CLEAR_INTS    = 8'd63,
        OP_MASK_INTS     = 8'd64
    } opcode_e;

    typedef enum logic [2:0] {
        REPLY_NONE,
        REPLY_OK,
        REPLY_ERROR,
        REPLY_UNKNOWN,
        REPLY_VERSION,
        REPLY_READ_REG,
        REPLY_INTERRUPT
    } reply_e;

    // Reply codes
    localparam byte_t RC_OK        = 8'h81;
    localparam byte_t RC_ERROR     = 8'h80;
    localparam byte_t RC_UNKNOWN   = 8'h85;
    localparam byte_t RC_INTERRUPT = 8'h50;  // Decimal 80 on the wire

    localparam byte_t VERSION_LO = 8'hBA;
    localparam byte_t VERSION_HI = 8'hCE;

endpackage

`default_nettype wire

/* design/int_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module int_controller #(
    parameter int INTS_TIMER = 1000000
) (
    input  wire                 clk,
    input  wire                 rst,
    input  wire s3g_pkg::word_t ints,
    input  wire logic           clear_wr,
    input  wire s3g_pkg::word_t clear_bits,
    input  wire logic           mask_wr,
    input  wire s3g_pkg::word_t mask_bits,
    input  wire logic           ints_ack,
    output s3g_pkg::word_t      ints_pending,
    output logic                ints_req
);
    import s3g_pkg::*;

    word_t       ints_mask;
    logic [31:0] ints_timer;  // Report rate limiter

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            ints_pending <= '0;
            ints_mask <= '1;
            ints_timer <= '0;
        end
        else
        begin
            // New edges beat a clear in the same cycle
            ints_pending <= (ints_pending & ~(clear_wr ? clear_bits : '0)) | ints;
            if (mask_wr)
                ints_mask <= mask_bits;
            if (clear_wr)
                ints_timer <= '0;
            else if (ints_ack)
                ints_timer <= 32'(INTS_TIMER);
            else if (ints_timer != '0)
                ints_timer <= ints_timer - 32'd1;
        end
    end

    assign ints_req = (ints_timer == '0) && ((ints_pending & ints_mask) != '0);

endmodule

`default_nettype wire

/* design/out_reg_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module out_reg_bank #(
    parameter int NUM_OUT_REGS = 8
) (
    input  wire                 clk,
    input  wire                 rst,
    input  wire logic           reg_wr,
    input  wire s3g_pkg::byte_t reg_addr,
    input  wire s3g_pkg::word_t reg_data,
    output s3g_pkg::word_t      out_regs [NUM_OUT_REGS]
);
    localparam int ADDR_W = (NUM_OUT_REGS > 1) ? $clog2(NUM_OUT_REGS) : 1;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < NUM_OUT_REGS; i++)
                out_regs[i] <= '0;
        end
        else if (reg_wr && int'(reg_addr) < NUM_OUT_REGS)  // Out of range dropped
            out_regs[reg_addr[ADDR_W-1:0]] <= reg_data;
    end

endmodule

`default_nettype wire

/* design/s3g_executor.sv */
`timescale 1ns/1ps
`default_nettype none

module s3g_executor #(
    parameter int NUM_OUT_REGS = 8,
    parameter int NUM_IN_REGS  = 8,
    parameter int INTS_TIMER   = 1000000
) (
    input  wire                    clk,
    input  wire                    rst,
    input  wire logic              rx_packet_done,
    input  wire logic              rx_packet_error,
    input  wire s3g_pkg::byte_t    rx_payload_len,
    input  wire s3g_pkg::payload_t rx_payload,
    input  wire logic              tx_busy,
    output logic                   tx_packet_wr,
    output s3g_pkg::byte_t         tx_payload_len,
    output s3g_pkg::payload_t      tx_payload,
    input  wire s3g_pkg::word_t    in_regs [NUM_IN_REGS],
    output s3g_pkg::word_t         out_regs [NUM_OUT_REGS],
    input  wire s3g_pkg::word_t    ints,
    output s3g_pkg::word_t         out_stbs
);
    import s3g_pkg::*;

    reply_e reply_kind;
    byte_t  in_sel;
    logic   reg_wr;
    byte_t  reg_addr;
    word_t  reg_data;
    logic   clear_wr;
    word_t  clear_bits;
    logic   mask_wr;
    word_t  mask_bits;
    logic   ints_ack;
    logic   ints_req;
    word_t  ints_pending;

    command_sequencer u_seq (
        .clk             (clk),
        .rst             (rst),
        .rx_packet_done  (rx_packet_done),
        .rx_packet_error (rx_packet_error),
        .rx_payload_len  (rx_payload_len),
        .rx_payload      (rx_payload),
        .tx_busy         (tx_busy),
        .ints_req        (ints_req),
        .reply_kind      (reply_kind),
        .in_sel          (in_sel),
        .reg_wr          (reg_wr),
        .reg_addr        (reg_addr),
        .reg_data        (reg_data),
        .out_stbs        (out_stbs),
        .clear_wr        (clear_wr),
        .clear_bits      (clear_bits),
        .mask_wr         (mask_wr),
        .mask_bits       (mask_bits),
        .ints_ack        (ints_ack)
    );

    reply_formatter #(.NUM_IN_REGS(NUM_IN_REGS)) u_fmt (
        .clk            (clk),
        .rst            (rst),
        .reply_kind     (reply_kind),
        .in_sel         (in_sel),
        .in_regs        (in_regs),
        .ints_pending   (ints_pending),
        .tx_packet_wr   (tx_packet_wr),
        .tx_payload_len (tx_payload_len),
        .tx_payload     (tx_payload)
    );

    out_reg_bank #(.NUM_OUT_REGS(NUM_OUT_REGS)) u_out_regs (
        .clk      (clk),
        .rst      (rst),
        .reg_wr   (reg_wr),
        .reg_addr (reg_addr),
        .reg_data (reg_data),
        .out_regs (out_regs)
    );

    int_controller #(.INTS_TIMER(INTS_TIMER)) u_ints (
        .clk          (clk),
        .rst          (rst),
        .ints         (ints),
        .clear_wr     (clear_wr),
        .clear_bits   (clear_bits),
        .mask_wr      (mask_wr),
        .mask_bits    (mask_bits),
        .ints_ack     (ints_ack),
        .ints_pending (ints_pending),
        .ints_req     (ints_req)
    );

endmodule

`default_nettype wire

/* flist.f */
common/s3g_pkg.sv
design/out_reg_bank.sv
design/int_controller.sv
command/command_sequencer.sv
command/reply_formatter.sv
design/s3g_executor.sv
tests/tb_s3g_executor.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module tb_s3g_executor -f flist.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "^Finished with no errors$" "$LOG"; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed"
exit 1

/* tests/tb_s3g_executor.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_s3g_executor;
    import s3g_pkg::*;

    localparam int NUM_OUT_REGS = 8;
    localparam int NUM_IN_REGS  = 8;
    localparam int INTS_TIMER   = 40;

    logic     clk;
    logic     rst;
    logic     rx_packet_done;
    logic     rx_packet_error;
    byte_t    rx_payload_len;
    payload_t rx_payload;
    logic     tx_busy = 1'b0;
    logic     tx_packet_wr;
    byte_t    tx_payload_len;
    payload_t tx_payload;
    word_t    in_regs [NUM_IN_REGS];
    word_t    out_regs [NUM_OUT_REGS];
    word_t    ints;
    word_t    out_stbs;

    integer   seed = 32'hb089879e;
    integer   busy_seed = 32'hb089879e;  // Own sequence for the transmitter model
    int       busy_cnt;
    int       quiet_cycles;
    word_t    exp_out [NUM_OUT_REGS];
    byte_t    rep_len;
    payload_t rep_payload;
    word_t    rep_stbs;

    s3g_executor #(
        .NUM_OUT_REGS (NUM_OUT_REGS),
        .NUM_IN_REGS  (NUM_IN_REGS),
        .INTS_TIMER   (INTS_TIMER)
    ) uut (
        .clk             (clk),
        .rst             (rst),
        .rx_packet_done  (rx_packet_done),
        .rx_packet_error (rx_packet_error),
        .rx_payload_len  (rx_payload_len),
        .rx_payload      (rx_payload),
        .tx_busy         (tx_busy),
        .tx_packet_wr    (tx_packet_wr),
        .tx_payload_len  (tx_payload_len),
        .tx_payload      (tx_payload),
        .in_regs         (in_regs),
        .out_regs        (out_regs),
        .ints            (ints),
        .out_stbs        (out_stbs)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Transmitter model busy for 1 to 5 cycles per packet
    always @(posedge clk)
    begin
        if (rst)
        begin
            tx_busy <= 1'b0;
            busy_cnt <= 0;
        end
        else if (tx_packet_wr)
        begin
            tx_busy <= 1'b1;
            busy_cnt <= 1 + $unsigned($random(busy_seed)) % 5;
        end
        else if (busy_cnt > 1)
            busy_cnt <= busy_cnt - 1;
        else
        begin
            busy_cnt <= 0;
            tx_busy <= 1'b0;
        end
    end

    always @(posedge clk)
    begin
        if (rst || tx_busy || tx_packet_wr)
            quiet_cycles <= 0;
        else if (quiet_cycles < 100)
            quiet_cycles <= quiet_cycles + 1;
    end

    // Strobes only ever ride along with a reply
    always @(negedge clk)
    begin
        if (!rst)
            assert (tx_packet_wr || out_stbs == '0)
            else report_mismatch($sformatf("out_stbs = %h outside a reply", out_stbs));
    end

    task automatic stop_on_failure(input string line);
        $display("%s", line);
        $display("Finished with errors");
        $fatal(1, "Simulation stopped at first failure");
    endtask

    task automatic report_mismatch(input string msg);
        stop_on_failure($sformatf("ERROR at time %0t: %s", $time, msg));
    endtask

    function automatic payload_t code_pl(input byte_t code);
        payload_t r;
        r = '0;
        r[0] = code;
        return r;
    endfunction

    function automatic payload_t put_word(input payload_t p, input int pos, input word_t w);
        payload_t r;
        r = p;
        for (int i = 0; i < 4; i++)
            r[pos + i] = w[8*i +: 8];  // LSB first
        return r;
    endfunction

    task automatic wait_for_packet(input int limit, output int cycles);
        cycles = 0;
        do
        begin
            @(negedge clk);
            cycles++;
        end while (!tx_packet_wr && cycles <= limit);
        rep_len = tx_payload_len;
        rep_payload = tx_payload;
        rep_stbs = out_stbs;
    endtask

    task automatic send_request(input logic is_error, input byte_t len, input payload_t pl,
                                input int exp_lat);
        int n;
        n = 0;
        do
        begin
            @(negedge clk);
            n++;
            if (n > 50)
                stop_on_failure("Timeout: DUT did not return to idle");
        end while (quiet_cycles < 2);
        @(posedge clk);
        rx_packet_done <= !is_error;
        rx_packet_error <= is_error;
        rx_payload_len <= len;
        rx_payload <= pl;
        @(posedge clk);  // Request edge
        rx_packet_done <= 1'b0;
        rx_packet_error <= 1'b0;
        wait_for_packet(20, n);
        if (n > 20)
            stop_on_failure("Timeout: no reply to a request");
        assert (n == exp_lat)
        else report_mismatch($sformatf("reply after %0d cycles, expected %0d", n, exp_lat));
    endtask

    task automatic check_reply(input byte_t exp_len, input payload_t exp_pl, input string what);
        assert (rep_len == exp_len)
        else report_mismatch($sformatf("%s length %0d, expected %0d", what, rep_len, exp_len));
        assert (rep_payload == exp_pl)
        else report_mismatch($sformatf("%s payload %h, expected %h", what, rep_payload, exp_pl));
    endtask

    task automatic check_out_regs();
        for (int i = 0; i < NUM_OUT_REGS; i++)
            assert (out_regs[i] == exp_out[i])
            else report_mismatch($sformatf("out_regs[%0d] = %h, expected %h",
                                           i, out_regs[i], exp_out[i]));
    endtask

    initial
    begin
        payload_t pl;
        payload_t exp_pl;
        word_t    data;
        byte_t    idx;
        int       bit_n;
        int       n;

        rst <= 1'b1;
        rx_packet_done <= 1'b0;
        rx_packet_error <= 1'b0;
        rx_payload_len <= '0;
        rx_payload <= '0;
        ints <= '0;
        for (int i = 0; i < NUM_IN_REGS; i++)
            in_regs[i] <= '0;
        for (int i = 0; i < NUM_OUT_REGS; i++)
            exp_out[i] = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_out_regs();
        assert (!tx_packet_wr) else report_mismatch("tx_packet_wr high after reset");

        // Protocol replies
        send_request(1'b0, 8'd0, '0, 1);
        check_reply(8'd1, code_pl(RC_OK), "empty payload");
        send_request(1'b0, 8'd1, code_pl(8'd7), 1);
        check_reply(8'd1, code_pl(RC_UNKNOWN), "unknown opcode");
        send_request(1'b1, 8'd0, '0, 1);
        check_reply(8'd1, code_pl(RC_ERROR), "packet error");
        send_request(1'b0, 8'd1, code_pl(OP_VERSION), 1);
        exp_pl = code_pl(RC_OK);
        exp_pl[1] = VERSION_LO;
        exp_pl[2] = VERSION_HI;
        check_reply(8'd3, exp_pl, "version");

        // Register writes with the last two out of range
        for (int k = 0; k < 8; k++)
        begin
            if (k < 6)
                idx = 8'($unsigned($random(seed)) % NUM_OUT_REGS);
            else
                idx = 8'(NUM_OUT_REGS + $unsigned($random(seed)) % (256 - NUM_OUT_REGS));
            data = $random(seed);
            pl = code_pl(OP_WRITE_OUT_REG);
            pl[1] = idx;
            pl = put_word(pl, 2, data);
            send_request(1'b0, 8'd6, pl, 1);
            check_reply(8'd1, code_pl(RC_OK), "register write");
            n = int'(idx);
            if (n < NUM_OUT_REGS)
                exp_out[n] = data;
            @(negedge clk);
            check_out_regs();
        end

        // Register reads with steady inputs
        @(posedge clk);
        for (int i = 0; i < NUM_IN_REGS; i++)
            in_regs[i] <= $random(seed);
        for (int k = 0; k < NUM_IN_REGS + 2; k++)
        begin
            idx = (k < NUM_IN_REGS) ? 8'(k) : 8'(255 - k);
            pl = code_pl(OP_READ_IN_REG);
            pl[1] = idx;
            send_request(1'b0, 8'd2, pl, 4);
            exp_pl = code_pl(RC_OK);
            if (k < NUM_IN_REGS)
                exp_pl = put_word(exp_pl, 1, in_regs[k]);
            check_reply(8'd5, exp_pl, "register read");
        end

        for (int k = 0; k < 3; k++)
        begin
            data = $random(seed);
            send_request(1'b0, 8'd5, put_word(code_pl(OP_OUT_STBS), 1, data), 1);
            check_reply(8'd1, code_pl(RC_OK), "strobe");
            assert (rep_stbs == data)
            else report_mismatch($sformatf("out_stbs = %h, expected %h", rep_stbs, data));
        end

        // Back-pressure with a request in the first busy cycle
        send_request(1'b0, 8'd1, code_pl(OP_VERSION), 1);
        @(posedge clk);
        rx_packet_done <= 1'b1;
        rx_payload_len <= 8'd0;
        @(posedge clk);
        rx_packet_done <= 1'b0;
        n = 0;
        do
        begin
            @(negedge clk);
            n++;
            if (n > 10)
                stop_on_failure("Timeout: tx_busy never fell");
        end while (tx_busy);
        wait_for_packet(20, n);
        assert (n > 20) else report_mismatch("reply to a request sent while busy");

        // Interrupt report and rate limit
        bit_n = $unsigned($random(seed)) % 32;
        @(posedge clk);
        ints <= 32'd1 << bit_n;
        @(posedge clk);
        ints <= '0;
        exp_pl = put_word(code_pl(RC_INTERRUPT), 1, 32'd1 << bit_n);
        wait_for_packet(10, n);
        if (n > 10)
            stop_on_failure("Timeout: no interrupt report");
        check_reply(8'd5, exp_pl, "interrupt report");
        wait_for_packet(INTS_TIMER + 10, n);
        assert (n > INTS_TIMER)
        else report_mismatch($sformatf("second report after only %0d cycles", n));
        if (n > INTS_TIMER + 10)
            stop_on_failure("Timeout: no repeated interrupt report");
        check_reply(8'd5, exp_pl, "repeated report");

        send_request(1'b0, 8'd5, put_word(code_pl(OP_CLEAR_INTS), 1, 32'd1 << bit_n), 1);
        check_reply(8'd1, code_pl(RC_OK), "clear interrupts");
        wait_for_packet(3 * INTS_TIMER, n);
        assert (n > 3 * INTS_TIMER) else report_mismatch("report after interrupts cleared");

        send_request(1'b0, 8'd5, put_word(code_pl(OP_MASK_INTS), 1, '0), 1);
        check_reply(8'd1, code_pl(RC_OK), "mask interrupts");
        @(posedge clk);
        ints <= 32'd1 << ((bit_n + 1) % 32);
        @(posedge clk);
        ints <= '0;
        wait_for_packet(2 * INTS_TIMER, n);
        assert (n > 2 * INTS_TIMER) else report_mismatch("report for a masked interrupt");

        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire
